//--- filelist.f
+incdir+.
range_reduction_pkg.sv
reduce_plan_if.sv
fp80_classify.sv
octant_map.sv
fp80_sub_norm.sv
reduction_ctrl.sv
fpu_range_reduction.sv
tb_range_reduction.sv

//--- tb_range_reduction.sv
// Self-checking testbench for the FP80 angle range reducer; run it as the simulation top
`timescale 1ns/1ps
`default_nettype none

`include "range_reduction_defs.svh"

module tb_range_reduction;

    localparam int PERIOD_NS   = 40;
    localparam int RANDOM_OPS  = 200;
    // Handshake test, zeros, error cases, directed, negated, random
    localparam int TOTAL_OPS   = 1 + 2 + 6 + 15 + 15 + RANDOM_OPS;
    localparam int WATCHDOG_NS = (TOTAL_OPS * 10 + 100) * PERIOD_NS;

    // Expected outputs of one operation
    typedef struct packed {
        range_reduction_pkg::fp80_t angle;
        logic [1:0]                 quadrant;
        logic                       swap;
        logic                       neg_sin;
        logic                       neg_cos;
        logic                       error;
    } expect_t;

    logic                       clk;
    logic                       reset;
    logic                       enable;
    range_reduction_pkg::fp80_t angle_in;
    range_reduction_pkg::fp80_t angle_out;
    logic [1:0]                 quadrant;
    logic                       swap_sincos;
    logic                       negate_sin;
    logic                       negate_cos;
    logic                       done;
    logic                       error;

    // Pending results, consumed by the compare process
    expect_t     expect_q[$];
    logic [15:0] lfsr_state;
    int          checks_total;
    int          errors_total;
    int          tests_done;
    int          test_checks_start;
    int          test_errors_start;

    fpu_range_reduction UUT (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .angle_in    (angle_in),
        .angle_out   (angle_out),
        .quadrant    (quadrant),
        .swap_sincos (swap_sincos),
        .negate_sin  (negate_sin),
        .negate_cos  (negate_cos),
        .done        (done),
        .error       (error)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    // ========================================================================
    // Reference model
    // ========================================================================

    // Magnitude compare, exponent first and mantissa on a tie
    function automatic logic at_or_above(input logic [79:0] a, input logic [79:0] b);
        if (a[78:64] != b[78:64]) begin
            return a[78:64] > b[78:64];
        end
        return a[63:0] >= b[63:0];
    endfunction

    // k times pi/4 for k = 1..7
    function automatic logic [79:0] pi_quarter_multiple(input int k);
        case (k)
            1: return `FP80_PI_4;
            2: return `FP80_PI_2;
            3: return `FP80_3PI_4;
            4: return `FP80_PI;
            5: return `FP80_5PI_4;
            6: return `FP80_3PI_2;
            7: return `FP80_7PI_4;
            default: return `FP80_ZERO;
        endcase
    endfunction

    function automatic expect_t reference_model(input range_reduction_pkg::fp80_t angle);
        expect_t     r;
        logic [79:0] mag;
        logic [79:0] kval;
        logic [79:0] minu;
        logic [79:0] subt;
        logic [14:0] ediff;
        logic [14:0] eres;
        logic [63:0] msub;
        logic [63:0] mres;
        logic        rev;
        int          oct;
        r   = '0;
        mag = {1'b0, angle[78:0]};
        // Zero of either sign gives all zeros
        if (mag == `FP80_ZERO) begin
            return r;
        end
        // Infinity, NaN and anything from 2pi up
        if (mag[78:64] == `EXP_MAX || at_or_above(mag, `FP80_2PI)) begin
            r.error = 1'b1;
            return r;
        end
        oct = 0;
        for (int k = 1; k < 8; k++) begin
            if (at_or_above(mag, pi_quarter_multiple(k))) begin
                oct++;
            end
        end
        rev = 1'b0;
        case (oct)
            0: kval = `FP80_ZERO;
            1: begin
                kval   = `FP80_PI_2;
                rev    = 1'b1;
                r.swap = 1'b1;
            end
            2: begin
                kval      = `FP80_PI_2;
                r.swap    = 1'b1;
                r.neg_cos = 1'b1;
            end
            3: begin
                kval      = `FP80_PI;
                rev       = 1'b1;
                r.neg_cos = 1'b1;
            end
            4: begin
                kval      = `FP80_PI;
                r.neg_cos = 1'b1;
            end
            5: begin
                kval      = `FP80_3PI_2;
                rev       = 1'b1;
                r.swap    = 1'b1;
                r.neg_cos = 1'b1;
            end
            6: begin
                kval   = `FP80_3PI_2;
                r.swap = 1'b1;
            end
            default: begin
                kval = `FP80_2PI;
                rev  = 1'b1;
            end
        endcase
        r.quadrant = 2'(oct / 2);
        r.neg_sin  = angle[79] ^ (oct >= 4);
        // Aligned truncating subtraction
        minu  = rev ? kval : mag;
        subt  = rev ? mag : kval;
        ediff = minu[78:64] - subt[78:64];
        if (ediff >= 15'd64) begin
            msub = '0;
        end else begin
            msub = subt[63:0] >> ediff;
        end
        mres = minu[63:0] - msub;
        eres = minu[78:64];
        // Left normalization, exponent untouched for a zero difference
        if (mres != '0) begin
            while (!mres[63]) begin
                mres = mres << 1;
                eres = eres - 15'd1;
            end
        end
        r.angle = {1'b0, eres, mres};
        return r;
    endfunction

    // ========================================================================
    // Checking and stimulus helpers
    // ========================================================================

    task automatic check_value(input string name, input logic [79:0] actual,
                               input logic [79:0] expected);
        checks_total++;
        if (actual !== expected) begin
            errors_total++;
            $display("** Error at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_value("angle_out", angle_out, e.angle);
        check_value("quadrant", quadrant, e.quadrant);
        check_value("swap_sincos", swap_sincos, e.swap);
        check_value("negate_sin", negate_sin, e.neg_sin);
        check_value("negate_cos", negate_cos, e.neg_cos);
        check_value("error", error, e.error);
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (done && expect_q.size() != 0) begin
            compare_outputs(expect_q.pop_front());
        end
    end

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};
        end
    endtask

    // Full enable/done cycle, with done held for hold extra cycles
    task automatic run_op(input range_reduction_pkg::fp80_t angle, input int hold);
        expect_t e;
        e = reference_model(angle);
        expect_q.push_back(e);
        @(posedge clk);
        #2;
        angle_in = angle;
        enable   = 1'b1;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        repeat (hold) begin
            @(negedge clk);
            check_value("done", done, 1);
            check_value("angle_out", angle_out, e.angle);
        end
        @(posedge clk);
        #2;
        enable = 1'b0;
        // Controller leaves ST_DONE on this edge
        @(posedge clk);
        @(negedge clk);
        check_value("done", done, 0);
    endtask

    task automatic start_test;
        test_checks_start = checks_total;
        test_errors_start = errors_total;
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("test %-16s checks %0d, errors %0d", name,
                 checks_total - test_checks_start, errors_total - test_errors_start);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        logic [79:0] directed[$];
        logic [63:0] bits;
        logic [79:0] rnd_angle;
        clk          = 1'b0;
        reset        = 1'b1;
        enable       = 1'b0;
        angle_in     = '0;
        lfsr_state   = 16'd34;
        checks_total = 0;
        errors_total = 0;
        tests_done   = 0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // Reset values, idle with enable low, then done hold and release
        start_test();
        @(negedge clk);
        check_value("angle_out", angle_out, 0);
        check_value("quadrant", quadrant, 0);
        check_value("swap_sincos", swap_sincos, 0);
        check_value("negate_sin", negate_sin, 0);
        check_value("negate_cos", negate_cos, 0);
        check_value("error", error, 0);
        @(posedge clk);
        #2;
        angle_in = 80'h3FFF_8000000000000000;
        repeat (4) begin
            @(negedge clk);
            check_value("done", done, 0);
        end
        run_op(80'h3FFF_8000000000000000, 3);
        end_test("handshake");

        start_test();
        run_op(80'h0000_0000000000000000, 1);
        run_op(80'h8000_0000000000000000, 1);
        end_test("zero");

        // Infinities, NaN, 2pi of both signs and 8.0
        start_test();
        run_op(80'h7FFF_8000000000000000, 1);
        run_op(80'hFFFF_8000000000000000, 1);
        run_op(80'h7FFF_C000000000000000, 1);
        run_op(`FP80_2PI, 1);
        run_op({1'b1, 79'(`FP80_2PI)}, 1);
        run_op(80'h4002_8000000000000000, 1);
        end_test("error_cases");

        // 0.5, 1, 2, 3, 3.5, 4.5, 5, 6 land in octants 0 to 7
        directed.push_back(80'h3FFE_8000000000000000);
        directed.push_back(80'h3FFF_8000000000000000);
        directed.push_back(80'h4000_8000000000000000);
        directed.push_back(80'h4000_C000000000000000);
        directed.push_back(80'h4000_E000000000000000);
        directed.push_back(80'h4001_9000000000000000);
        directed.push_back(80'h4001_A000000000000000);
        directed.push_back(80'h4001_C000000000000000);
        for (int k = 1; k < 8; k++) begin
            directed.push_back(pi_quarter_multiple(k));
        end

        start_test();
        foreach (directed[i]) begin
            run_op(directed[i], 0);
        end
        end_test("octants");

        start_test();
        foreach (directed[i]) begin
            run_op({1'b1, directed[i][78:0]}, 0);
        end
        end_test("octants_negated");

        // Exponent from 2^-8 to 2^2, integer bit set
        start_test();
        for (int n = 0; n < RANDOM_OPS; n++) begin
            take_bits(1, bits);
            rnd_angle[79] = bits[0];
            take_bits(4, bits);
            rnd_angle[78:64] = 15'h3FF7 + 15'(bits[3:0] % 11);
            take_bits(63, bits);
            rnd_angle[63:0] = {1'b1, bits[62:0]};
            run_op(rnd_angle, 0);
        end
        end_test("random");

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks_total, errors_total);
        if (errors_total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Bounded by the number of operations
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fpu_range_reduction.sv
// Top level of the FP80 angle range reducer, connecting classify, octant map, subtractor and FSM
`timescale 1ns/1ps
`default_nettype none

`include "range_reduction_defs.svh"

module fpu_range_reduction (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic [`FP80_W-1:0] angle_in,
    output logic [`FP80_W-1:0] angle_out,
    output logic [1:0]        quadrant,
    output logic              swap_sincos,
    output logic              negate_sin,
    output logic              negate_cos,
    output logic              done,
    output logic              error
);

    // Captured magnitude and the subtractor result
    range_reduction_pkg::fp80_t angle_abs;
    range_reduction_pkg::fp80_t reduced;
    logic                       is_zero;
    logic                       is_error;

    // Octant decision shared by subtractor and controller
    reduce_plan_if plan_bus ();

    fp80_classify u_classify (
        .angle_abs (angle_abs),
        .is_zero   (is_zero),
        .is_error  (is_error)
    );

    octant_map u_octant_map (
        .angle_abs (angle_abs),
        .plan      (plan_bus.source)
    );

    fp80_sub_norm u_sub_norm (
        .angle_abs (angle_abs),
        .plan      (plan_bus.sub_side),
        .result    (reduced)
    );

    reduction_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .angle_in    (angle_in),
        .is_zero     (is_zero),
        .is_error    (is_error),
        .reduced     (reduced),
        .plan        (plan_bus.ctrl_side),
        .angle_abs   (angle_abs),
        .angle_out   (angle_out),
        .quadrant    (quadrant),
        .swap_sincos (swap_sincos),
        .negate_sin  (negate_sin),
        .negate_cos  (negate_cos),
        .done        (done),
        .error       (error)
    );

endmodule

`default_nettype wire

//--- reduction_ctrl.sv
// Controller for the range reducer: input capture, sequencing and the result registers
`timescale 1ns/1ps
`default_nettype none

`include "range_reduction_defs.svh"

module reduction_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enable,
    input  range_reduction_pkg::fp80_t    angle_in,
    input  logic                          is_zero,
    input  logic                          is_error,
    input  range_reduction_pkg::fp80_t    reduced,
    reduce_plan_if.ctrl_side              plan,
    output range_reduction_pkg::fp80_t    angle_abs,
    output range_reduction_pkg::fp80_t    angle_out,
    output range_reduction_pkg::quadrant_t quadrant,
    output logic                          swap_sincos,
    output logic                          negate_sin,
    output logic                          negate_cos,
    output logic                          done,
    output logic                          error
);

    range_reduction_pkg::ctrl_state_e state;
    // Sign of the captured angle
    logic                             angle_sign;

    // ======================================================================
    // Input capture
    // ======================================================================

    // Magnitude feeds classify, octant map and subtractor
    always_ff @(posedge clk) begin
        if (state == range_reduction_pkg::ST_IDLE && enable) begin
            angle_abs  <= {1'b0, angle_in[`FP80_W-2:0]};
            angle_sign <= angle_in[`FP80_W-1];
        end
    end

    // ======================================================================
    // Sequencing and results
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= range_reduction_pkg::ST_IDLE;
            angle_out   <= `FP80_ZERO;
            quadrant    <= '0;
            swap_sincos <= 1'b0;
            negate_sin  <= 1'b0;
            negate_cos  <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
        end else begin
            case (state)
                range_reduction_pkg::ST_IDLE: begin
                    done <= 1'b0;
                    if (enable) begin
                        state <= range_reduction_pkg::ST_CHECK;
                    end
                end

                // Zero and error cases finish here with cleared flags
                range_reduction_pkg::ST_CHECK: begin
                    error <= is_error;
                    if (is_zero || is_error) begin
                        angle_out   <= `FP80_ZERO;
                        quadrant    <= '0;
                        swap_sincos <= 1'b0;
                        negate_sin  <= 1'b0;
                        negate_cos  <= 1'b0;
                        state       <= range_reduction_pkg::ST_DONE;
                    end else begin
                        state <= range_reduction_pkg::ST_REDUCE;
                    end
                end

                // Plan and subtractor settled on the captured magnitude
                range_reduction_pkg::ST_REDUCE: begin
                    angle_out   <= reduced;
                    quadrant    <= plan.quadrant;
                    swap_sincos <= plan.swap;
                    negate_sin  <= angle_sign ^ plan.sin_flip;
                    negate_cos  <= plan.cos_neg;
                    state       <= range_reduction_pkg::ST_DONE;
                end

                // Hold results while the host keeps enable high
                default: begin
                    if (enable) begin
                        done <= 1'b1;
                    end else begin
                        done  <= 1'b0;
                        state <= range_reduction_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fp80_sub_norm.sv
// Aligned truncating FP80 magnitude subtraction with leading-zero normalization
`timescale 1ns/1ps
`default_nettype none

`include "range_reduction_defs.svh"

module fp80_sub_norm (
    input  range_reduction_pkg::fp80_t angle_abs,
    reduce_plan_if.sub_side            plan,
    output range_reduction_pkg::fp80_t result
);

    range_reduction_pkg::fp80_t      minuend;
    range_reduction_pkg::fp80_t      subtrahend;
    range_reduction_pkg::fp80_exp_t  exp_a;
    range_reduction_pkg::fp80_exp_t  exp_b;
    range_reduction_pkg::fp80_exp_t  exp_diff;
    range_reduction_pkg::fp80_exp_t  exp_out;
    range_reduction_pkg::fp80_mant_t mant_a;
    range_reduction_pkg::fp80_mant_t mant_b;
    range_reduction_pkg::fp80_mant_t aligned;
    range_reduction_pkg::fp80_mant_t diff;
    range_reduction_pkg::fp80_mant_t mant_out;
    // 0..64, 64 only for a zero difference
    logic [6:0]                      lead_zeros;

    // ======================================================================
    // Operand order and alignment
    // ======================================================================

    // Larger value always ends up as the minuend
    assign minuend    = plan.reverse ? plan.ref_const : angle_abs;
    assign subtrahend = plan.reverse ? angle_abs : plan.ref_const;

    assign exp_a  = minuend[`FP80_W-2:`MANT_W];
    assign exp_b  = subtrahend[`FP80_W-2:`MANT_W];
    assign mant_a = minuend[`MANT_W-1:0];
    assign mant_b = subtrahend[`MANT_W-1:0];

    assign exp_diff = exp_a - exp_b;

    // Bits shifted out are dropped
    always_comb begin
        if (exp_a == exp_b) begin
            aligned = mant_b;
        end else if (exp_diff >= `MANT_W) begin
            aligned = '0;
        end else begin
            aligned = mant_b >> exp_diff;
        end
    end

    assign diff = mant_a - aligned;

    // ======================================================================
    // Normalization
    // ======================================================================

    // Highest set bit wins since the scan runs upward
    always_comb begin
        lead_zeros = 7'd64;
        for (int i = 0; i < `MANT_W; i++) begin
            if (diff[i]) begin
                lead_zeros = 7'(`MANT_W - 1 - i);
            end
        end
    end

    // A zero difference keeps the minuend exponent
    always_comb begin
        if (diff != '0) begin
            mant_out = diff << lead_zeros;
            exp_out  = exp_a - range_reduction_pkg::fp80_exp_t'(lead_zeros);
        end else begin
            mant_out = diff;
            exp_out  = exp_a;
        end
    end

    // Reduced magnitude is always positive
    assign result = {1'b0, exp_out, mant_out};

endmodule

`default_nettype wire

//--- octant_map.sv
// Octant selection against the seven pi/4 boundaries and the per-octant reduction plan
`timescale 1ns/1ps
`default_nettype none

`include "range_reduction_defs.svh"

module octant_map (
    input  range_reduction_pkg::fp80_t angle_abs,
    reduce_plan_if.source              plan
);

    // One bit per boundary reached
    logic [6:0]                   at_or_above;
    range_reduction_pkg::octant_t octant;

    // ======================================================================
    // Boundary compares
    // ======================================================================

    always_comb begin
        at_or_above[0] = range_reduction_pkg::fp80_gte(angle_abs, `FP80_PI_4);
        at_or_above[1] = range_reduction_pkg::fp80_gte(angle_abs, `FP80_PI_2);
        at_or_above[2] = range_reduction_pkg::fp80_gte(angle_abs, `FP80_3PI_4);
        at_or_above[3] = range_reduction_pkg::fp80_gte(angle_abs, `FP80_PI);
        at_or_above[4] = range_reduction_pkg::fp80_gte(angle_abs, `FP80_5PI_4);
        at_or_above[5] = range_reduction_pkg::fp80_gte(angle_abs, `FP80_3PI_2);
        at_or_above[6] = range_reduction_pkg::fp80_gte(angle_abs, `FP80_7PI_4);
    end

    // Octant is the number of boundaries reached
    // Compares are monotonic, so this is a thermometer count
    always_comb begin
        octant = '0;
        for (int i = 0; i < 7; i++) begin
            octant = octant + range_reduction_pkg::octant_t'(at_or_above[i]);
        end
    end

    // ======================================================================
    // Octant table
    // ======================================================================

    always_comb begin
        plan.ref_const = `FP80_ZERO;
        plan.reverse   = 1'b0;
        plan.swap      = 1'b0;
        plan.cos_neg   = 1'b0;
        case (octant)
            // Already inside [0, pi/4)
            3'd0: begin
                plan.ref_const = `FP80_ZERO;
                plan.reverse   = 1'b0;
            end
            // pi/2 minus angle
            3'd1: begin
                plan.ref_const = `FP80_PI_2;
                plan.reverse   = 1'b1;
                plan.swap      = 1'b1;
            end
            // Angle minus pi/2
            3'd2: begin
                plan.ref_const = `FP80_PI_2;
                plan.swap      = 1'b1;
                plan.cos_neg   = 1'b1;
            end
            // pi minus angle
            3'd3: begin
                plan.ref_const = `FP80_PI;
                plan.reverse   = 1'b1;
                plan.cos_neg   = 1'b1;
            end
            // Angle minus pi
            3'd4: begin
                plan.ref_const = `FP80_PI;
                plan.cos_neg   = 1'b1;
            end
            // 3pi/2 minus angle
            3'd5: begin
                plan.ref_const = `FP80_3PI_2;
                plan.reverse   = 1'b1;
                plan.swap      = 1'b1;
                plan.cos_neg   = 1'b1;
            end
            // Angle minus 3pi/2, cos back to positive
            3'd6: begin
                plan.ref_const = `FP80_3PI_2;
                plan.swap      = 1'b1;
            end
            // 2pi minus angle
            default: begin
                plan.ref_const = `FP80_2PI;
                plan.reverse   = 1'b1;
            end
        endcase
    end

    // Two octants per quadrant
    assign plan.quadrant = octant[2:1];
    // Lower half plane flips the sign of sin
    assign plan.sin_flip = octant[2];

endmodule

`default_nettype wire

//--- fp80_classify.sv
// Combinational zero, infinity/NaN and out-of-range detection on the captured magnitude
`timescale 1ns/1ps
`default_nettype none

`include "range_reduction_defs.svh"

module fp80_classify (
    input  range_reduction_pkg::fp80_t angle_abs,
    output logic                       is_zero,
    output logic                       is_error
);

    range_reduction_pkg::fp80_exp_t  exp_f;
    range_reduction_pkg::fp80_mant_t mant_f;
    logic                            is_inf;
    logic                            is_nan;
    logic                            too_big;

    // Field split
    assign exp_f  = angle_abs[`FP80_W-2:`MANT_W];
    assign mant_f = angle_abs[`MANT_W-1:0];

    // Both fields clear
    assign is_zero = (exp_f == '0) && (mant_f == '0);

    // Infinity keeps only the integer bit in the mantissa
    assign is_inf = (exp_f == `EXP_MAX) && (mant_f == {1'b1, {(`MANT_W-1){1'b0}}});
    // Any other pattern with the top exponent
    assign is_nan = (exp_f == `EXP_MAX) && !is_inf;

    // No wrap is done, so 2pi and above cannot be reduced
    assign too_big = range_reduction_pkg::fp80_gte(angle_abs, `FP80_2PI);

    assign is_error = is_inf || is_nan || too_big;

endmodule

`default_nettype wire

//--- reduce_plan_if.sv
// Reduction plan bus from octant selection to the subtractor and the controller
`timescale 1ns/1ps
`default_nettype none

`include "range_reduction_defs.svh"

interface reduce_plan_if;

    // Subtraction operand and direction
    logic [`FP80_W-1:0] ref_const;
    // Set means constant minus magnitude
    logic               reverse;

    // Result flags for the chosen octant
    logic               swap;
    logic               cos_neg;
    // Octant sits in quadrant III or IV
    logic               sin_flip;
    logic [1:0]         quadrant;

    modport source    (output ref_const, reverse, swap, cos_neg, sin_flip, quadrant);
    modport sub_side  (input ref_const, reverse);
    modport ctrl_side (input swap, cos_neg, sin_flip, quadrant);

endinterface

`default_nettype wire

//--- range_reduction_pkg.sv
// Types and the FP80 magnitude compare used throughout the range reducer design
`default_nettype none

`include "range_reduction_defs.svh"

package range_reduction_pkg;

    // Angle word and its fields
    typedef logic [`FP80_W-1:0] fp80_t;
    typedef logic [`EXP_W-1:0]  fp80_exp_t;
    typedef logic [`MANT_W-1:0] fp80_mant_t;

    // Octant 0..7 of the magnitude in [0, 2pi)
    typedef logic [2:0] octant_t;
    // 0 = I, 1 = II, 2 = III, 3 = IV
    typedef logic [1:0] quadrant_t;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_REDUCE,
        ST_DONE
    } ctrl_state_e;

    // Magnitude a >= b for positive normalized words
    // Exponent decides first, mantissa breaks the tie
    function automatic logic fp80_gte(input fp80_t a, input fp80_t b);
        if (a[`FP80_W-2:`MANT_W] != b[`FP80_W-2:`MANT_W]) begin
            return a[`FP80_W-2:`MANT_W] > b[`FP80_W-2:`MANT_W];
        end
        return a[`MANT_W-1:0] >= b[`MANT_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- range_reduction_defs.svh
// Field widths, exponent limits and FP80 pi-multiple constants shared by the reducer and testbench
`ifndef RANGE_REDUCTION_DEFS_SVH
`define RANGE_REDUCTION_DEFS_SVH

// ==========================================================================
// FP80 field layout
// ==========================================================================

// Full word, sign at the top
`define FP80_W  80
// Biased exponent width
`define EXP_W   15
// Mantissa including the explicit integer bit
`define MANT_W  64
// Exponent code reserved for infinity and NaN
`define EXP_MAX 15'h7FFF

// ==========================================================================
// Boundary constants
// ==========================================================================

// Mantissas are truncated, not rounded
`define FP80_ZERO  80'h0000_0000000000000000
`define FP80_PI_4  80'h3FFE_C90FDAA22168C234
`define FP80_PI_2  80'h3FFF_C90FDAA22168C234
`define FP80_3PI_4 80'h4000_96CBE3F9990E91A7
`define FP80_PI    80'h4000_C90FDAA22168C234
// 5pi/4 still fits below 4.0
`define FP80_5PI_4 80'h4000_FB53D14AA9C2F2C1
`define FP80_3PI_2 80'h4001_96CBE3F9990E91A7
`define FP80_7PI_4 80'h4001_AFEDDF4DDD3BA9EE
// Upper limit of the supported range
`define FP80_2PI   80'h4001_C90FDAA22168C234

`endif
